// ==== hdl/cu_pkg.sv ====
package cu_pkg;

    // Instruction opcodes, bits [15:12] of the instruction word
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_LDI  = 4'h1,
        OP_ADD  = 4'h2,
        OP_SUB  = 4'h3,
        OP_AND  = 4'h4,
        OP_OR   = 4'h5,
        OP_XOR  = 4'h6,
        OP_LD   = 4'h7,
        OP_ST   = 4'h8,
        OP_JMP  = 4'h9,
        OP_JZ   = 4'hA,
        OP_HALT = 4'hB
    } opcode_t;

    // Decoder FSM states
    typedef enum logic [2:0] {
        ST_FETCH,
        ST_EXEC,
        ST_MEM_READ,
        ST_MEM_WRITE,
        ST_HALT
    } state_t;

    typedef logic [1:0] reg_sel_t;

    localparam logic [15:0] RESET_PC = 16'h0000;
    localparam int NUM_REGS = 4;

    // Instruction word fields
    localparam int OPC_MSB = 15;
    localparam int OPC_LSB = 12;
    localparam int RD_MSB  = 11;
    localparam int RD_LSB  = 10;
    localparam int RS_MSB  = 9;
    localparam int RS_LSB  = 8;
    localparam int IMM_MSB = 7;
    localparam int IMM_LSB = 0;

endpackage

// ==== hdl/alu_pkg.sv ====
package alu_pkg;

    typedef enum logic [2:0] {
        ALU_PASS_B,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    // Flag vector layout
    localparam int FLAG_Z = 0;
    localparam int FLAG_C = 1;
    localparam int FLAG_W = 2;

endpackage

// ==== hdl/instruction_decoder.sv ====
module instruction_decoder (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic [15:0]                instr_i,
    input  logic                       mem_ack_i,
    input  logic [alu_pkg::FLAG_W-1:0] flags_i,
    output cu_pkg::reg_sel_t           rd_sel_o,
    output cu_pkg::reg_sel_t           rs_sel_o,
    output logic                       reg_write_o,
    output logic                       wb_from_mem_o,
    output logic                       flag_write_o,
    output alu_pkg::alu_op_t           alu_op_o,
    output logic                       b_is_imm_o,
    output logic [15:0]                imm_o,
    output logic                       pc_inc_o,
    output logic                       pc_jump_o,
    output logic                       pc_branch_o,
    output logic                       mem_read_en_o,
    output logic                       mem_write_en_o,
    output logic                       addr_from_reg_o,
    output logic                       halted_o
);
    cu_pkg::state_t  state_q;
    cu_pkg::state_t  state_d;
    cu_pkg::opcode_t opcode;
    logic [15:0]     instr_q;
    logic [7:0]      imm8;
    logic            run_q;
    logic            fetch_ack;

    assign opcode   = cu_pkg::opcode_t'(instr_q[cu_pkg::OPC_MSB:cu_pkg::OPC_LSB]);
    assign rd_sel_o = instr_q[cu_pkg::RD_MSB:cu_pkg::RD_LSB];
    assign rs_sel_o = instr_q[cu_pkg::RS_MSB:cu_pkg::RS_LSB];
    assign imm8     = instr_q[cu_pkg::IMM_MSB:cu_pkg::IMM_LSB];

    // JZ offset is signed, all other immediates unsigned
    assign imm_o = (opcode == cu_pkg::OP_JZ) ? {{8{imm8[7]}}, imm8} : {8'h00, imm8};

    assign fetch_ack = (state_q == cu_pkg::ST_FETCH) && run_q && mem_ack_i;

    // run_q holds off the first fetch until reset has gone
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= cu_pkg::ST_FETCH;
            run_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            run_q   <= 1'b1;
        end
    end

    // Instruction register
    always_ff @(posedge clk) begin
        if (fetch_ack) begin
            instr_q <= instr_i;
        end
    end

    always_comb begin
        case (opcode)
            cu_pkg::OP_ADD: alu_op_o = alu_pkg::ALU_ADD;
            cu_pkg::OP_SUB: alu_op_o = alu_pkg::ALU_SUB;
            cu_pkg::OP_AND: alu_op_o = alu_pkg::ALU_AND;
            cu_pkg::OP_OR:  alu_op_o = alu_pkg::ALU_OR;
            cu_pkg::OP_XOR: alu_op_o = alu_pkg::ALU_XOR;
            default:        alu_op_o = alu_pkg::ALU_PASS_B;
        endcase
    end

    always_comb begin
        state_d         = state_q;
        reg_write_o     = 1'b0;
        wb_from_mem_o   = 1'b0;
        flag_write_o    = 1'b0;
        b_is_imm_o      = 1'b0;
        pc_inc_o        = 1'b0;
        pc_jump_o       = 1'b0;
        pc_branch_o     = 1'b0;
        mem_read_en_o   = 1'b0;
        mem_write_en_o  = 1'b0;
        addr_from_reg_o = 1'b0;
        halted_o        = 1'b0;

        case (state_q)
            cu_pkg::ST_FETCH: begin
                mem_read_en_o = run_q;
                pc_inc_o      = fetch_ack;
                if (fetch_ack) begin
                    state_d = cu_pkg::ST_EXEC;
                end
            end
            cu_pkg::ST_EXEC: begin
                state_d = cu_pkg::ST_FETCH;
                case (opcode)
                    cu_pkg::OP_LDI: begin
                        reg_write_o = 1'b1;
                        b_is_imm_o  = 1'b1;
                    end
                    cu_pkg::OP_ADD, cu_pkg::OP_SUB, cu_pkg::OP_AND,
                    cu_pkg::OP_OR, cu_pkg::OP_XOR: begin
                        reg_write_o  = 1'b1;
                        flag_write_o = 1'b1;
                    end
                    cu_pkg::OP_LD:   state_d = cu_pkg::ST_MEM_READ;
                    cu_pkg::OP_ST:   state_d = cu_pkg::ST_MEM_WRITE;
                    cu_pkg::OP_JMP:  pc_jump_o = 1'b1;
                    cu_pkg::OP_JZ:   pc_branch_o = flags_i[alu_pkg::FLAG_Z];
                    cu_pkg::OP_HALT: state_d = cu_pkg::ST_HALT;
                    default: ;
                endcase
            end
            cu_pkg::ST_MEM_READ: begin
                mem_read_en_o   = 1'b1;
                addr_from_reg_o = 1'b1;
                wb_from_mem_o   = 1'b1;
                reg_write_o     = mem_ack_i;
                if (mem_ack_i) begin
                    state_d = cu_pkg::ST_FETCH;
                end
            end
            cu_pkg::ST_MEM_WRITE: begin
                mem_write_en_o  = 1'b1;
                addr_from_reg_o = 1'b1;
                if (mem_ack_i) begin
                    state_d = cu_pkg::ST_FETCH;
                end
            end
            cu_pkg::ST_HALT: halted_o = 1'b1;
            default: state_d = cu_pkg::ST_FETCH;
        endcase
    end
endmodule

// ==== hdl/register_file.sv ====
module register_file (
    input  logic                       clk,
    input  logic                       rst_i,
    input  cu_pkg::reg_sel_t           rd_sel_i,
    input  cu_pkg::reg_sel_t           rs_sel_i,
    input  logic                       write_en_i,
    input  logic [15:0]                wdata_i,
    input  logic                       flag_write_i,
    input  logic [alu_pkg::FLAG_W-1:0] flags_i,
    output logic [15:0]                rd_data_o,
    output logic [15:0]                rs_data_o,
    output logic [alu_pkg::FLAG_W-1:0] flags_o
);
    logic [15:0]                regs_q [cu_pkg::NUM_REGS];
    logic [alu_pkg::FLAG_W-1:0] flags_q;

    // Write port, always to rd
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < cu_pkg::NUM_REGS; i++) begin
                regs_q[i] <= 16'h0000;
            end
        end else if (write_en_i) begin
            regs_q[rd_sel_i] <= wdata_i;
        end
    end

    // Z and C
    always_ff @(posedge clk) begin
        if (rst_i) begin
            flags_q <= '0;
        end else if (flag_write_i) begin
            flags_q <= flags_i;
        end
    end

    assign rd_data_o = regs_q[rd_sel_i];
    assign rs_data_o = regs_q[rs_sel_i];
    assign flags_o   = flags_q;
endmodule

// ==== hdl/program_counter.sv ====
module program_counter (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        inc_i,
    input  logic        jump_i,
    input  logic        branch_i,
    input  logic [15:0] target_i,
    output logic [15:0] pc_o
);
    logic [15:0] pc_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= cu_pkg::RESET_PC;
        end else if (jump_i) begin
            pc_q <= target_i;
        end else if (branch_i) begin
            // target_i is already sign extended
            pc_q <= pc_q + target_i;
        end else if (inc_i) begin
            pc_q <= pc_q + 16'd1;
        end
    end

    assign pc_o = pc_q;
endmodule

// ==== hdl/alu.sv ====
module alu (
    input  logic [15:0]                a_i,
    input  logic [15:0]                b_i,
    input  alu_pkg::alu_op_t           op_i,
    output logic [15:0]                result_o,
    output logic [alu_pkg::FLAG_W-1:0] flags_o
);
    logic [15:0] result;
    logic        carry;

    always_comb begin
        result = 16'h0000;
        carry  = 1'b0;
        case (op_i)
            alu_pkg::ALU_PASS_B: result = b_i;
            alu_pkg::ALU_ADD: begin
                {carry, result} = {1'b0, a_i} + {1'b0, b_i};
            end
            alu_pkg::ALU_SUB: begin
                // Carry is not borrow
                {carry, result} = {1'b0, a_i} + {1'b0, ~b_i} + 17'd1;
            end
            alu_pkg::ALU_AND: result = a_i & b_i;
            alu_pkg::ALU_OR:  result = a_i | b_i;
            alu_pkg::ALU_XOR: result = a_i ^ b_i;
            default:          result = b_i;
        endcase
    end

    always_comb begin
        flags_o                 = '0;
        flags_o[alu_pkg::FLAG_Z] = (result == 16'h0000);
        flags_o[alu_pkg::FLAG_C] = carry;
    end

    assign result_o = result;
endmodule

// ==== hdl/control_unit.sv ====
module control_unit (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic [15:0]                mem_data_i,
    input  logic                       mem_ack_i,
    input  logic [15:0]                alu_result_i,
    input  logic [alu_pkg::FLAG_W-1:0] alu_flags_i,
    output logic [15:0]                mem_addr_o,
    output logic [15:0]                mem_data_o,
    output logic                       mem_read_en_o,
    output logic                       mem_write_en_o,
    output logic [15:0]                alu_a_o,
    output logic [15:0]                alu_b_o,
    output alu_pkg::alu_op_t           alu_op_o,
    output logic                       halted_o
);
    cu_pkg::reg_sel_t           id_rd_sel;
    cu_pkg::reg_sel_t           id_rs_sel;
    logic                       id_reg_write;
    logic                       id_wb_from_mem;
    logic                       id_flag_write;
    logic                       id_b_is_imm;
    logic [15:0]                id_imm;
    logic                       id_pc_inc;
    logic                       id_pc_jump;
    logic                       id_pc_branch;
    logic                       id_addr_from_reg;
    logic [15:0]                rf_rd_data;
    logic [15:0]                rf_rs_data;
    logic [alu_pkg::FLAG_W-1:0] rf_flags;
    logic [15:0]                rf_wdata;
    logic [15:0]                pc_value;

    // Operands: A is always rd, B is rs or the immediate
    assign alu_a_o = rf_rd_data;
    assign alu_b_o = id_b_is_imm ? id_imm : rf_rs_data;

    // Fetch from PC, loads and stores through rs
    assign mem_addr_o = id_addr_from_reg ? rf_rs_data : pc_value;
    assign mem_data_o = rf_rd_data;

    assign rf_wdata = id_wb_from_mem ? mem_data_i : alu_result_i;

    instruction_decoder id (
        .clk            (clk),
        .rst_i          (rst_i),
        .instr_i        (mem_data_i),
        .mem_ack_i      (mem_ack_i),
        .flags_i        (rf_flags),
        .rd_sel_o       (id_rd_sel),
        .rs_sel_o       (id_rs_sel),
        .reg_write_o    (id_reg_write),
        .wb_from_mem_o  (id_wb_from_mem),
        .flag_write_o   (id_flag_write),
        .alu_op_o       (alu_op_o),
        .b_is_imm_o     (id_b_is_imm),
        .imm_o          (id_imm),
        .pc_inc_o       (id_pc_inc),
        .pc_jump_o      (id_pc_jump),
        .pc_branch_o    (id_pc_branch),
        .mem_read_en_o  (mem_read_en_o),
        .mem_write_en_o (mem_write_en_o),
        .addr_from_reg_o(id_addr_from_reg),
        .halted_o       (halted_o)
    );

    register_file reg_file (
        .clk         (clk),
        .rst_i       (rst_i),
        .rd_sel_i    (id_rd_sel),
        .rs_sel_i    (id_rs_sel),
        .write_en_i  (id_reg_write),
        .wdata_i     (rf_wdata),
        .flag_write_i(id_flag_write),
        .flags_i     (alu_flags_i),
        .rd_data_o   (rf_rd_data),
        .rs_data_o   (rf_rs_data),
        .flags_o     (rf_flags)
    );

    program_counter pc (
        .clk     (clk),
        .rst_i   (rst_i),
        .inc_i   (id_pc_inc),
        .jump_i  (id_pc_jump),
        .branch_i(id_pc_branch),
        .target_i(id_imm),
        .pc_o    (pc_value)
    );
endmodule

// ==== hdl/cpu_core.sv ====
module cpu_core (
    input  logic        clk,
    input  logic        rst_i,
    input  logic [15:0] mem_data_i,
    input  logic        mem_ack_i,
    output logic [15:0] mem_addr_o,
    output logic [15:0] mem_data_o,
    output logic        mem_read_en_o,
    output logic        mem_write_en_o,
    output logic        halted_o
);
    logic [15:0]                alu_a;
    logic [15:0]                alu_b;
    logic [15:0]                alu_result;
    logic [alu_pkg::FLAG_W-1:0] alu_flags;
    alu_pkg::alu_op_t           alu_op;

    control_unit cu (
        .clk           (clk),
        .rst_i         (rst_i),
        .mem_data_i    (mem_data_i),
        .mem_ack_i     (mem_ack_i),
        .alu_result_i  (alu_result),
        .alu_flags_i   (alu_flags),
        .mem_addr_o    (mem_addr_o),
        .mem_data_o    (mem_data_o),
        .mem_read_en_o (mem_read_en_o),
        .mem_write_en_o(mem_write_en_o),
        .alu_a_o       (alu_a),
        .alu_b_o       (alu_b),
        .alu_op_o      (alu_op),
        .halted_o      (halted_o)
    );

    alu alu_unit (
        .a_i     (alu_a),
        .b_i     (alu_b),
        .op_i    (alu_op),
        .result_o(alu_result),
        .flags_o (alu_flags)
    );
endmodule

// ==== verification/cpu_checker.sv ====
module cpu_checker (
    input logic        clk,
    input logic        rst_i,
    input logic [15:0] mem_addr_o,
    input logic [15:0] mem_data_o,
    input logic        mem_read_en_o,
    input logic        mem_write_en_o,
    input logic        mem_ack_i,
    input logic        halted_o
);
    timeunit 1ns;
    timeprecision 1ps;

    a_rw_exclusive: assert property (@(posedge clk) disable iff (rst_i)
        !(mem_read_en_o && mem_write_en_o))
        else $error("read and write enable high together");

    a_read_hold: assert property (@(posedge clk) disable iff (rst_i)
        (mem_read_en_o && !mem_ack_i) |=> (mem_read_en_o && $stable(mem_addr_o)))
        else $error("read request dropped or address moved before ack");

    a_write_hold: assert property (@(posedge clk) disable iff (rst_i)
        (mem_write_en_o && !mem_ack_i) |=>
            (mem_write_en_o && $stable(mem_addr_o) && $stable(mem_data_o)))
        else $error("write request dropped or address or data moved before ack");

    a_halt_idle: assert property (@(posedge clk) disable iff (rst_i)
        halted_o |-> !(mem_read_en_o || mem_write_en_o))
        else $error("memory request while halted");
endmodule

bind cpu_core cpu_checker chk (.*);

// ==== verification/cpu_tb.sv ====
module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        rst_i;
    logic [15:0] mem_data_i;
    logic        mem_ack_i;
    logic [15:0] mem_addr_o;
    logic [15:0] mem_data_o;
    logic        mem_read_en_o;
    logic        mem_write_en_o;
    logic        halted_o;

    logic [31:0] lfsr;
    logic [15:0] mem [0:255];
    logic [15:0] mmem [0:255];
    logic [15:0] exp_regs [4];
    logic [15:0] exp_rd [$];
    logic [15:0] exp_wa [$];
    logic [15:0] exp_wd [$];
    logic        ack_nxt;
    logic [15:0] rdata_nxt;
    logic        busy;
    logic [1:0]  wait_cnt;
    logic        post_rst;
    int          cycles;

    cpu_core DUT (.*);

    function automatic logic next_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], next_bit()};
        end
        return v;
    endfunction

    function automatic logic [15:0] enc(input logic [3:0] op, input logic [1:0] rd,
                                        input logic [1:0] rs, input logic [7:0] imm);
        return {op, rd, rs, imm};
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s at %0t", msg, $time);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input logic [15:0] act, input logic [15:0] exp, input string msg);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s (got %h, expected %h)", $time, msg, act, exp);
            $display("CHECKS FAILED");
            $fatal(1, "simulation stopped");
        end
    endtask

    task automatic build_program();
        int          idx;
        int          tgt;
        logic [2:0]  kind;
        logic [1:0]  base;
        logic [3:0]  op;
        idx = 0;
        for (int a = 0; a < 256; a++) begin
            mem[a] = 16'(a * 40503) ^ 16'h5A5A;
        end
        for (int r = 0; r < 4; r++) begin
            mem[idx] = enc(cu_pkg::OP_LDI, 2'(r), 2'd0, 8'(rand_bits(8)));
            idx++;
        end
        while (idx < 55) begin
            kind = 3'(rand_bits(3));
            if (kind < 3'd4) begin
                op = 4'(cu_pkg::OP_ADD) + 4'(rand_bits(3) % 16'd5);
                mem[idx] = enc(op, 2'(rand_bits(2)), 2'(rand_bits(2)), 8'h00);
            end else if (kind == 3'd4) begin
                mem[idx] = enc(cu_pkg::OP_LDI, 2'(rand_bits(2)), 2'd0, 8'(rand_bits(8)));
            end else if (kind == 3'd5 && idx < 54) begin
                // Base register set right before the access
                base = 2'(rand_bits(2));
                mem[idx] = enc(cu_pkg::OP_LDI, base, 2'd0, {1'b1, 7'(rand_bits(7))});
                idx++;
                op = next_bit() ? 4'(cu_pkg::OP_ST) : 4'(cu_pkg::OP_LD);
                mem[idx] = enc(op, 2'(rand_bits(2)), base, 8'h00);
            end else if (kind == 3'd6) begin
                tgt = idx + 1 + int'(rand_bits(2));
                if (tgt > 55) tgt = 55;
                mem[idx] = enc(cu_pkg::OP_JMP, 2'd0, 2'd0, 8'(tgt));
            end else if (kind == 3'd7) begin
                tgt = idx + 1 + int'(rand_bits(2));
                if (tgt > 55) tgt = 55;
                mem[idx] = enc(cu_pkg::OP_JZ, 2'd0, 2'd0, 8'(tgt - idx - 1));
            end else begin
                mem[idx] = enc(cu_pkg::OP_NOP, 2'd0, 2'd0, 8'h00);
            end
            idx++;
        end
        // Never land on LD or ST without its base LDI
        for (int i = 4; i < 55; i++) begin
            op = mem[i][15:12];
            tgt = (op == 4'(cu_pkg::OP_JMP)) ? int'(mem[i][7:0]) : i + 1 + int'(mem[i][7:0]);
            if ((op == 4'(cu_pkg::OP_JMP) || op == 4'(cu_pkg::OP_JZ)) &&
                (mem[tgt][15:12] == 4'(cu_pkg::OP_LD) || mem[tgt][15:12] == 4'(cu_pkg::OP_ST))) begin
                mem[i][7:0] = mem[i][7:0] + 8'd1;
            end
        end
        for (int r = 0; r < 4; r++) begin
            mem[55 + 2 * r] = enc(cu_pkg::OP_LDI, 2'd3, 2'd0, 8'(250 + r));
            mem[56 + 2 * r] = enc(cu_pkg::OP_ST, 2'(r), 2'd3, 8'h00);
        end
        mem[63] = enc(cu_pkg::OP_HALT, 2'd0, 2'd0, 8'h00);
    endtask

    task automatic run_model();
        logic [15:0] r [4];
        logic [15:0] pc;
        logic [15:0] ins;
        logic [15:0] res;
        logic [3:0]  op;
        logic [1:0]  rd;
        logic [1:0]  rs;
        logic [7:0]  imm;
        logic        z;
        logic        done;
        int          steps;
        r = '{default: 16'h0000};
        pc = 16'h0000;
        z = 1'b0;
        done = 1'b0;
        steps = 0;
        mmem = mem;
        while (!done && steps < 1000) begin
            exp_rd.push_back(pc);
            ins = mmem[pc[7:0]];
            pc = pc + 16'd1;
            {op, rd, rs, imm} = ins;
            res = 16'h0000;
            case (op)
                cu_pkg::OP_LDI: r[rd] = {8'h00, imm};
                cu_pkg::OP_ADD, cu_pkg::OP_SUB, cu_pkg::OP_AND, cu_pkg::OP_OR,
                cu_pkg::OP_XOR: begin
                    case (op)
                        cu_pkg::OP_ADD: res = r[rd] + r[rs];
                        cu_pkg::OP_SUB: res = r[rd] - r[rs];
                        cu_pkg::OP_AND: res = r[rd] & r[rs];
                        cu_pkg::OP_OR:  res = r[rd] | r[rs];
                        default:        res = r[rd] ^ r[rs];
                    endcase
                    r[rd] = res;
                    z = (res == 16'h0000);
                end
                cu_pkg::OP_LD: begin
                    exp_rd.push_back(r[rs]);
                    r[rd] = mmem[r[rs][7:0]];
                end
                cu_pkg::OP_ST: begin
                    exp_wa.push_back(r[rs]);
                    exp_wd.push_back(r[rd]);
                    mmem[r[rs][7:0]] = r[rd];
                end
                cu_pkg::OP_JMP: pc = {8'h00, imm};
                cu_pkg::OP_JZ: if (z) pc = pc + {{8{imm[7]}}, imm};
                cu_pkg::OP_HALT: done = 1'b1;
                default: ;
            endcase
            steps++;
        end
        exp_regs = r;
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Memory model: decide at the falling edge, drive at the rising edge
    always @(negedge clk) begin
        ack_nxt = 1'b0;
        if (rst_i || post_rst) begin
            check({15'd0, mem_read_en_o}, 16'h0, "read enable in reset");
            check({15'd0, mem_write_en_o}, 16'h0, "write enable in reset");
            check({15'd0, halted_o}, 16'h0, "halted in reset");
        end
        post_rst = rst_i;
        if (rst_i) begin
            busy = 1'b0;
        end else if ((mem_read_en_o || mem_write_en_o) && !mem_ack_i) begin
            if (!busy) begin
                busy = 1'b1;
                wait_cnt = 2'(rand_bits(2));
            end
            if (wait_cnt == 2'd0) begin
                ack_nxt = 1'b1;
                busy = 1'b0;
                if (mem_read_en_o) begin
                    if (exp_rd.size() == 0) stop_with_error("Unexpected extra read request");
                    check(mem_addr_o, exp_rd.pop_front(), "read address");
                    rdata_nxt = mem[mem_addr_o[7:0]];
                end else begin
                    if (exp_wa.size() == 0) stop_with_error("Unexpected extra write request");
                    check(mem_addr_o, exp_wa.pop_front(), "write address");
                    check(mem_data_o, exp_wd.pop_front(), "write data");
                    mem[mem_addr_o[7:0]] = mem_data_o;
                end
            end else begin
                wait_cnt = wait_cnt - 2'd1;
            end
        end
    end

    always @(posedge clk) begin
        mem_ack_i  <= ack_nxt;
        mem_data_i <= rdata_nxt;
    end

    initial begin
        rst_i = 1'b1;
        mem_ack_i = 1'b0;
        mem_data_i = 16'h0000;
        ack_nxt = 1'b0;
        rdata_nxt = 16'h0000;
        busy = 1'b0;
        wait_cnt = 2'd0;
        post_rst = 1'b1;
        lfsr = 32'd79190;
        build_program();
        run_model();
        repeat (5) @(posedge clk);
        rst_i <= 1'b0;
        cycles = 0;
        while (!halted_o) begin
            @(negedge clk);
            cycles++;
            if (cycles > 20000) stop_with_error("Timeout waiting for halted_o");
        end
        check(16'(exp_rd.size()), 16'h0, "reads left in the model");
        check(16'(exp_wa.size()), 16'h0, "writes left in the model");
        cycles = 0;
        while (cycles < 10) begin
            @(negedge clk);
            cycles++;
            check({15'd0, mem_read_en_o | mem_write_en_o}, 16'h0, "request after halt");
        end
        // Epilogue stores r0 to r3 at 250 to 253
        for (int k = 0; k < 4; k++) begin
            check(mem[250 + k], exp_regs[k], "final register store");
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end
endmodule

// ==== compile.f ====
hdl/cu_pkg.sv
hdl/alu_pkg.sv
hdl/instruction_decoder.sv
hdl/register_file.sv
hdl/program_counter.sv
hdl/alu.sv
hdl/control_unit.sv
hdl/cpu_core.sv
verification/cpu_checker.sv
verification/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module cpu_tb -f compile.f -o cpu_sim
./obj_dir/cpu_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
